// File: design/coreTypes.sv
package coreTypes;

   // datapath width
   localparam int WordW = 32;

   typedef logic [WordW-1:0] word_t;
   typedef logic [4:0] regAddr_t;
   typedef logic [4:0] shamt_t;
   typedef logic [5:0] opcode_t;
   typedef logic [5:0] funct_t;

   // primary opcodes
   localparam opcode_t OpRType = 6'h00;
   localparam opcode_t OpAddiu = 6'h09;
   localparam opcode_t OpSlti  = 6'h0a;
   localparam opcode_t OpSltiu = 6'h0b;
   localparam opcode_t OpAndi  = 6'h0c;
   localparam opcode_t OpOri   = 6'h0d;
   localparam opcode_t OpXori  = 6'h0e;
   localparam opcode_t OpLui   = 6'h0f;
   localparam opcode_t OpLb    = 6'h20;
   localparam opcode_t OpLh    = 6'h21;
   localparam opcode_t OpLw    = 6'h23;
   localparam opcode_t OpLbu   = 6'h24;
   localparam opcode_t OpLhu   = 6'h25;
   localparam opcode_t OpSb    = 6'h28;
   localparam opcode_t OpSh    = 6'h29;
   localparam opcode_t OpSw    = 6'h2b;

   // function codes, r-type only
   localparam funct_t FnSll  = 6'h00;
   localparam funct_t FnSrl  = 6'h02;
   localparam funct_t FnSra  = 6'h03;
   localparam funct_t FnAddu = 6'h21;
   localparam funct_t FnSubu = 6'h23;
   localparam funct_t FnAnd  = 6'h24;
   localparam funct_t FnOr   = 6'h25;
   localparam funct_t FnXor  = 6'h26;
   localparam funct_t FnNor  = 6'h27;
   localparam funct_t FnSlt  = 6'h2a;
   localparam funct_t FnSltu = 6'h2b;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
      aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
   } aluOp_t;

   typedef enum logic [1:0] {memByte, memHalf, memWord} memSize_t;

   // control word built in decode
   typedef struct packed {
      aluOp_t   aluOp;
      logic     useImm;
      logic     useShamt;
      logic     memRead;
      logic     memWrite;
      memSize_t memSize;
      logic     loadSigned;
      logic     regWrite;
   } ctl_t;

   // decode to execute
   typedef struct packed {
      logic     valid;
      ctl_t     ctl;
      regAddr_t rs;
      regAddr_t rt;
      regAddr_t dest;
      word_t    rd1;
      word_t    rd2;
      word_t    imm;
      shamt_t   shamt;
   } deStage_t;

   // execute to result
   typedef struct packed {
      logic     valid;
      logic     regWrite;
      logic     memRead;
      memSize_t memSize;
      logic     loadSigned;
      regAddr_t dest;
      word_t    aluResult;
      logic [1:0] byteOffset;
   } erStage_t;

   // register write port, also the forwarding source
   typedef struct packed {
      logic     en;
      regAddr_t addr;
      word_t    data;
   } wbPort_t;

endpackage

// File: design/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
   input  coreTypes::word_t  a,
   input  coreTypes::word_t  b,
   input  coreTypes::aluOp_t op,
   output coreTypes::word_t  y
);
   import coreTypes::*;

   // shift count from the low bits of a
   shamt_t shiftAmt;

   assign shiftAmt = a[4:0];

   always_comb begin
      case (op)
         aluAdd:  y = a + b;
         aluSub:  y = a - b;
         aluAnd:  y = a & b;
         aluOr:   y = a | b;
         aluXor:  y = a ^ b;
         aluNor:  y = ~(a | b);
         // compares yield 0 or 1
         aluSlt: begin
            y = {31'b0, $signed(a) < $signed(b)};
         end
         aluSltu: begin
            y = {31'b0, a < b};
         end
         // shifts move b, a holds the count
         aluSll:  y = b << shiftAmt;
         aluSrl:  y = b >> shiftAmt;
         aluSra: begin
            y = $signed(b) >>> shiftAmt;
         end
         aluLui:  y = {b[15:0], 16'b0};
         default: y = a + b;
      endcase
   end

endmodule

// File: design/regFile.sv
`timescale 1ns/1ps

module regFile (
   input  logic               clk,
   input  coreTypes::regAddr_t rs,
   input  coreTypes::regAddr_t rt,
   output coreTypes::word_t    rd1,
   output coreTypes::word_t    rd2,
   input  coreTypes::wbPort_t  wb
);
   import coreTypes::*;

   // r0 is not stored
   word_t regs [1:31];

   always_ff @(posedge clk) begin
      if (wb.en && (wb.addr != '0)) begin
         regs[wb.addr] <= wb.data;
      end
   end

   // write-through covers an instruction two slots behind the writer
   always_comb begin
      if (rs == '0) begin
         rd1 = '0;
      end else if (wb.en && (wb.addr == rs)) begin
         rd1 = wb.data;
      end else begin
         rd1 = regs[rs];
      end
      if (rt == '0) begin
         rd2 = '0;
      end else if (wb.en && (wb.addr == rt)) begin
         rd2 = wb.data;
      end else begin
         rd2 = regs[rt];
      end
   end

endmodule

// File: design/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
   input  logic               clk,
   input  logic               reset,
   input  coreTypes::word_t    instr,
   input  logic               instrValid,
   output coreTypes::regAddr_t rs,
   output coreTypes::regAddr_t rt,
   input  coreTypes::word_t    rd1,
   input  coreTypes::word_t    rd2,
   output coreTypes::deStage_t de
);
   import coreTypes::*;

   opcode_t  opcode;
   funct_t   funct;
   regAddr_t rd;
   ctl_t     ctl;
   logic     known;
   logic     signExt;
   logic     destIsRd;
   deStage_t deNext;

   // instruction fields
   assign opcode = instr[31:26];
   assign rs     = instr[25:21];
   assign rt     = instr[20:16];
   assign rd     = instr[15:11];
   assign funct  = instr[5:0];

   always_comb begin
      ctl       = '0;
      ctl.aluOp = aluAdd;
      known     = 1'b1;
      signExt   = 1'b1;
      destIsRd  = 1'b0;
      case (opcode)
         OpRType: begin
            destIsRd     = 1'b1;
            ctl.regWrite = 1'b1;
            case (funct)
               FnAddu: ctl.aluOp = aluAdd;
               FnSubu: ctl.aluOp = aluSub;
               FnAnd:  ctl.aluOp = aluAnd;
               FnOr:   ctl.aluOp = aluOr;
               FnXor:  ctl.aluOp = aluXor;
               FnNor:  ctl.aluOp = aluNor;
               FnSlt:  ctl.aluOp = aluSlt;
               FnSltu: ctl.aluOp = aluSltu;
               FnSll: begin
                  ctl.aluOp    = aluSll;
                  ctl.useShamt = 1'b1;
               end
               FnSrl: begin
                  ctl.aluOp    = aluSrl;
                  ctl.useShamt = 1'b1;
               end
               FnSra: begin
                  ctl.aluOp    = aluSra;
                  ctl.useShamt = 1'b1;
               end
               // unsupported function code goes down the pipe as a bubble
               default: known = 1'b0;
            endcase
         end
         OpAddiu, OpSlti, OpSltiu: begin
            ctl.useImm   = 1'b1;
            ctl.regWrite = 1'b1;
            ctl.aluOp    = (opcode == OpSlti)  ? aluSlt :
                           (opcode == OpSltiu) ? aluSltu : aluAdd;
         end
         OpAndi, OpOri, OpXori, OpLui: begin
            // logic forms and lui take the zero-extended immediate
            signExt      = 1'b0;
            ctl.useImm   = 1'b1;
            ctl.regWrite = 1'b1;
            ctl.aluOp    = (opcode == OpAndi) ? aluAnd :
                           (opcode == OpOri)  ? aluOr  :
                           (opcode == OpXori) ? aluXor : aluLui;
         end
         OpLb, OpLh, OpLw, OpLbu, OpLhu: begin
            ctl.useImm     = 1'b1;
            ctl.memRead    = 1'b1;
            ctl.regWrite   = 1'b1;
            ctl.loadSigned = (opcode == OpLb) || (opcode == OpLh);
            ctl.memSize    = (opcode == OpLw) ? memWord :
                             (opcode == OpLb || opcode == OpLbu) ? memByte : memHalf;
         end
         OpSb, OpSh, OpSw: begin
            ctl.useImm   = 1'b1;
            ctl.memWrite = 1'b1;
            ctl.memSize  = (opcode == OpSw) ? memWord :
                           (opcode == OpSb) ? memByte : memHalf;
         end
         default: known = 1'b0;
      endcase
   end

   always_comb begin
      deNext.valid = instrValid && known;
      deNext.ctl   = ctl;
      deNext.rs    = rs;
      deNext.rt    = rt;
      // r-type writes rd, everything else rt
      deNext.dest  = destIsRd ? rd : rt;
      deNext.rd1   = rd1;
      deNext.rd2   = rd2;
      deNext.imm   = {{16{signExt & instr[15]}}, instr[15:0]};
      deNext.shamt = instr[10:6];
   end

   always_ff @(posedge clk) begin
      de <= deNext;
      if (!reset) begin
         de.valid <= 1'b0;
      end
   end

endmodule

// File: design/executeStage.sv
`timescale 1ns/1ps

module executeStage (
   input  logic               clk,
   input  logic               reset,
   input  coreTypes::deStage_t de,
   input  coreTypes::wbPort_t  wb,
   output coreTypes::word_t    memAddr,
   output coreTypes::word_t    memWData,
   output logic [3:0]          memWEn,
   output coreTypes::erStage_t er
);
   import coreTypes::*;

   word_t    fwdA;
   word_t    fwdB;
   word_t    opA;
   word_t    opB;
   word_t    aluResult;
   erStage_t erNext;

   // result stage holds the previous instruction, its wb is final
   assign fwdA = (wb.en && (wb.addr == de.rs)) ? wb.data : de.rd1;
   assign fwdB = (wb.en && (wb.addr == de.rt)) ? wb.data : de.rd2;

   assign opA = de.ctl.useShamt ? {27'b0, de.shamt} : fwdA;
   assign opB = de.ctl.useImm ? de.imm : fwdB;

   aluUnit u_aluUnit (
      .a  (opA),
      .b  (opB),
      .op (de.ctl.aluOp),
      .y  (aluResult)
   );

   // loads and stores address through the adder
   assign memAddr = aluResult;

   // store data copied to every lane, enables pick the lanes
   always_comb begin
      memWEn = 4'b0000;
      case (de.ctl.memSize)
         memByte: memWData = {4{fwdB[7:0]}};
         memHalf: memWData = {2{fwdB[15:0]}};
         default: memWData = fwdB;
      endcase
      if (de.valid && de.ctl.memWrite) begin
         case (de.ctl.memSize)
            memByte: memWEn = 4'b0001 << aluResult[1:0];
            memHalf: memWEn = aluResult[1] ? 4'b1100 : 4'b0011;
            default: memWEn = 4'b1111;
         endcase
      end
   end

   always_comb begin
      erNext.valid      = de.valid;
      erNext.regWrite   = de.ctl.regWrite;
      erNext.memRead    = de.ctl.memRead;
      erNext.memSize    = de.ctl.memSize;
      erNext.loadSigned = de.ctl.loadSigned;
      erNext.dest       = de.dest;
      erNext.aluResult  = aluResult;
      erNext.byteOffset = aluResult[1:0];
   end

   always_ff @(posedge clk) begin
      er <= erNext;
      if (!reset) begin
         er.valid <= 1'b0;
      end
   end

endmodule

// File: design/dataMem.sv
`timescale 1ns/1ps

module dataMem #(
   parameter int DmemAddrW = 8
) (
   input  logic             clk,
   input  coreTypes::word_t addr,
   input  coreTypes::word_t wData,
   input  logic [3:0]       wEn,
   output coreTypes::word_t rData
);
   import coreTypes::*;

   localparam int Depth = 2 ** DmemAddrW;

   word_t mem [0:Depth-1];

   // word index, upper address bits ignored so it wraps
   logic [DmemAddrW-1:0] wordAddr;

   assign wordAddr = addr[DmemAddrW+1:2];

   // one lane per byte enable
   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (wEn[i]) begin
            mem[wordAddr][8*i +: 8] <= wData[8*i +: 8];
         end
      end
   end

   // read data lands with the er register
   always_ff @(posedge clk) begin
      rData <= mem[wordAddr];
   end

endmodule

// File: design/resultStage.sv
`timescale 1ns/1ps

module resultStage (
   input  coreTypes::erStage_t er,
   input  coreTypes::word_t    rData,
   output coreTypes::wbPort_t  wb
);
   import coreTypes::*;

   logic [7:0]  loadByte;
   logic [15:0] loadHalf;
   word_t       loadWord;

   // pick the addressed lane out of the word
   assign loadByte = rData[8*er.byteOffset +: 8];
   assign loadHalf = er.byteOffset[1] ? rData[31:16] : rData[15:0];

   always_comb begin
      case (er.memSize)
         memByte: begin
            loadWord = {{24{er.loadSigned & loadByte[7]}}, loadByte};
         end
         memHalf: begin
            loadWord = {{16{er.loadSigned & loadHalf[15]}}, loadHalf};
         end
         default: loadWord = rData;
      endcase
   end

   // no write for bubbles, stores or r0
   assign wb.en   = er.valid && er.regWrite && (er.dest != '0);
   assign wb.addr = er.dest;
   assign wb.data = er.memRead ? loadWord : er.aluResult;

endmodule

// File: design/pipeCore.sv
`timescale 1ns/1ps

module pipeCore #(
   parameter int DmemAddrW = 8
) (
   input  logic               clk,
   input  logic               reset,
   input  coreTypes::word_t   instr,
   input  logic               instrValid,
   output coreTypes::wbPort_t wb
);
   import coreTypes::*;

   regAddr_t   rs;
   regAddr_t   rt;
   word_t      rd1;
   word_t      rd2;
   deStage_t   de;
   erStage_t   er;
   word_t      memAddr;
   word_t      memWData;
   logic [3:0] memWEn;
   word_t      rData;

   // decode reads registers in the issue cycle
   decodeStage u_decodeStage (
      .clk        (clk),
      .reset      (reset),
      .instr      (instr),
      .instrValid (instrValid),
      .rs         (rs),
      .rt         (rt),
      .rd1        (rd1),
      .rd2        (rd2),
      .de         (de)
   );

   regFile u_regFile (
      .clk (clk),
      .rs  (rs),
      .rt  (rt),
      .rd1 (rd1),
      .rd2 (rd2),
      .wb  (wb)
   );

   // wb feeds back for forwarding
   executeStage u_executeStage (
      .clk      (clk),
      .reset    (reset),
      .de       (de),
      .wb       (wb),
      .memAddr  (memAddr),
      .memWData (memWData),
      .memWEn   (memWEn),
      .er       (er)
   );

   dataMem #(
      .DmemAddrW (DmemAddrW)
   ) u_dataMem (
      .clk   (clk),
      .addr  (memAddr),
      .wData (memWData),
      .wEn   (memWEn),
      .rData (rData)
   );

   resultStage u_resultStage (
      .er    (er),
      .rData (rData),
      .wb    (wb)
   );

endmodule

// File: verif/pipeCore_chk.sv
`timescale 1ns/1ps

module pipeCore_chk (
   input logic               clk,
   input logic               reset,
   input logic               instrValid,
   input coreTypes::wbPort_t wb
);

   // read back by the testbench
   int failCount = 0;

   // pipeline registers cleared, so nothing retires next cycle
   property quietAfterReset;
      @(posedge clk) !reset |=> !wb.en;
   endproperty

   // r0 writes are suppressed in the result stage
   property noWriteToZero;
      @(posedge clk) disable iff (!reset) wb.en |-> (wb.addr != 5'd0);
   endproperty

   // fixed two-clock latency
   property wbFollowsIssue;
      @(posedge clk) disable iff (!reset) wb.en |-> $past(instrValid, 2);
   endproperty

   assert property (quietAfterReset) else begin
      failCount++;
      $error("wb.en high in the cycle after reset");
   end

   assert property (noWriteToZero) else begin
      failCount++;
      $error("wb.en high with wb.addr zero");
   end

   assert property (wbFollowsIssue) else begin
      failCount++;
      $error("wb.en without a valid instruction two cycles earlier");
   end

endmodule

bind pipeCore pipeCore_chk u_pipeCore_chk (
   .clk        (clk),
   .reset      (reset),
   .instrValid (instrValid),
   .wb         (wb)
);

// File: verif/pipeCoreTb.sv
`timescale 1ns/1ps

module pipeCoreTb;
   import coreTypes::*;

   localparam int DmemAddrW   = 8;
   localparam int MemWords    = 2 ** DmemAddrW;
   localparam int NumRandom   = 2000;
   localparam int ResetCycles = 8;
   // worst case two slots per random instruction, plus init, reset, drain and margin
   localparam int TimeoutNs   = (2 * NumRandom + 2 * 31 + ResetCycles + 2 + 100) * 10;

   logic    clk;
   logic    reset;
   word_t   instr;
   logic    instrValid;
   wbPort_t wb;

   // reference machine state
   word_t      modelRegs [0:31];
   word_t      modelMem  [0:MemWords-1];
   logic [3:0] byteValid [0:MemWords-1];
   // expected wb per issue slot, oldest first
   wbPort_t    expQ [$];

   funct_t  aluFuncts [0:10];
   opcode_t immOps    [0:6];

   int errorCount;
   int checkCount;

   pipeCore #(
      .DmemAddrW (DmemAddrW)
   ) u_pipeCore (
      .clk        (clk),
      .reset      (reset),
      .instr      (instr),
      .instrValid (instrValid),
      .wb         (wb)
   );

   always #5 clk = ~clk;

   function automatic word_t encR(regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                  logic [4:0] sh, funct_t fn);
      return {OpRType, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t encI(opcode_t op, regAddr_t rs, regAddr_t rt,
                                  logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // mostly r0..r7 so that hazards show up often
   function automatic regAddr_t pickReg();
      logic [31:0] r;
      r = $urandom();
      if (r[7:4] == 4'h0) begin
         return r[12:8];
      end
      return {2'b00, r[2:0]};
   endfunction

   task automatic compareValue(input string name, input word_t got, input word_t expected);
      checkCount++;
      if (got !== expected) begin
         errorCount++;
         $display("FAIL %s: got %h expected %h at %0t", name, got, expected, $time);
      end
   endtask

   task automatic storeByte(input int idx, input logic [1:0] lane, input logic [7:0] v);
      modelMem[idx][8*lane +: 8] = v;
      byteValid[idx][lane] = 1'b1;
   endtask

   // executes one instruction on the model, returns the wb it should cause
   task automatic predict(input word_t ins, output wbPort_t expWb);
      opcode_t     op;
      funct_t      fn;
      regAddr_t    rs;
      regAddr_t    rt;
      regAddr_t    rd;
      regAddr_t    dest;
      logic [4:0]  sh;
      word_t       a;
      word_t       b;
      word_t       sext;
      word_t       zext;
      word_t       addr;
      word_t       res;
      word_t       shifted;
      logic [1:0]  lane;
      logic        known;
      logic        writes;
      int          idx;
      op     = ins[31:26];
      rs     = ins[25:21];
      rt     = ins[20:16];
      rd     = ins[15:11];
      sh     = ins[10:6];
      fn     = ins[5:0];
      a      = modelRegs[rs];
      b      = modelRegs[rt];
      sext   = {{16{ins[15]}}, ins[15:0]};
      zext   = {16'h0000, ins[15:0]};
      addr   = a + sext;
      lane   = addr[1:0];
      idx    = int'(addr[DmemAddrW+1:2]);
      // loaded lanes sit at the bottom after this shift
      shifted = modelMem[idx] >> (8 * addr[1:0]);
      known  = 1'b1;
      writes = 1'b1;
      dest   = rt;
      res    = '0;
      case (op)
         OpRType: begin
            dest = rd;
            case (fn)
               FnAddu: res = a + b;
               FnSubu: res = a - b;
               FnAnd:  res = a & b;
               FnOr:   res = a | b;
               FnXor:  res = a ^ b;
               FnNor:  res = ~(a | b);
               FnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               FnSltu: res = (a < b) ? 32'd1 : 32'd0;
               FnSll:  res = b << sh;
               FnSrl:  res = b >> sh;
               // fill vacated bits with the sign
               FnSra:  res = (b >> sh) | (b[31] ? ~(32'hffffffff >> sh) : 32'h0);
               default: known = 1'b0;
            endcase
         end
         OpAddiu: res = a + sext;
         OpSlti:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
         OpSltiu: res = (a < sext) ? 32'd1 : 32'd0;
         OpAndi:  res = a & zext;
         OpOri:   res = a | zext;
         OpXori:  res = a ^ zext;
         OpLui:   res = {ins[15:0], 16'h0000};
         OpLb:    res = {{24{shifted[7]}}, shifted[7:0]};
         OpLbu:   res = {24'h0, shifted[7:0]};
         OpLh:    res = {{16{shifted[15]}}, shifted[15:0]};
         OpLhu:   res = {16'h0, shifted[15:0]};
         OpLw:    res = modelMem[idx];
         OpSb: begin
            writes = 1'b0;
            storeByte(idx, lane, b[7:0]);
         end
         OpSh: begin
            writes = 1'b0;
            storeByte(idx, {lane[1], 1'b0}, b[7:0]);
            storeByte(idx, {lane[1], 1'b1}, b[15:8]);
         end
         OpSw: begin
            writes = 1'b0;
            for (int i = 0; i < 4; i++) begin
               storeByte(idx, 2'(i), b[8*i +: 8]);
            end
         end
         default: known = 1'b0;
      endcase
      expWb.en   = known && writes && (dest != 5'd0);
      expWb.addr = dest;
      expWb.data = res;
      if (expWb.en) begin
         modelRegs[dest] = res;
      end
   endtask

   // one issue slot: drive, queue the prediction, check the slot two back
   task automatic issue(input word_t ins, input logic valid);
      wbPort_t expWb;
      wbPort_t oldest;
      @(posedge clk);
      #1;
      instr      = ins;
      instrValid = valid;
      expWb      = '0;
      if (valid) begin
         predict(ins, expWb);
      end
      expQ.push_back(expWb);
      @(negedge clk);
      oldest = expQ.pop_front();
      compareValue("wb.en", {31'b0, wb.en}, {31'b0, oldest.en});
      if (oldest.en) begin
         compareValue("wb.addr", {27'b0, wb.addr}, {27'b0, oldest.addr});
         compareValue("wb.data", wb.data, oldest.data);
      end
   endtask

   task automatic randomInstr(output word_t ins);
      logic [31:0] rnd;
      logic [31:0] pick;
      logic [31:0] sel;
      logic [7:0]  wordIdx;
      logic [1:0]  lane;
      funct_t      fn;
      int          kind;
      rnd     = $urandom();
      pick    = $urandom();
      sel     = $urandom();
      kind    = int'(pick % 100);
      lane    = rnd[9:8];
      // mostly a small window so loads find written words
      wordIdx = rnd[20] ? rnd[7:0] : {3'b000, rnd[4:0]};
      if (kind < 40) begin
         fn = aluFuncts[int'(sel % 11)];
         if (pick[31:28] == 4'h0) begin
            fn = 6'h3e;
         end
         ins = encR(pickReg(), pickReg(), pickReg(), rnd[10:6], fn);
      end else if (kind < 65) begin
         ins = encI(immOps[int'(sel % 7)], pickReg(), pickReg(), rnd[31:16]);
      end else if (kind < 80) begin
         if (byteValid[wordIdx] != 4'hf) begin
            // word not fully known yet, fill it first
            ins = encI(OpSw, 5'd0, pickReg(), {6'b0, wordIdx, 2'b00});
         end else begin
            case (sel % 5)
               0: ins = encI(OpLb, 5'd0, pickReg(), {6'b0, wordIdx, lane});
               1: ins = encI(OpLbu, 5'd0, pickReg(), {6'b0, wordIdx, lane});
               2: ins = encI(OpLh, 5'd0, pickReg(), {6'b0, wordIdx, lane[1], 1'b0});
               3: ins = encI(OpLhu, 5'd0, pickReg(), {6'b0, wordIdx, lane[1], 1'b0});
               default: ins = encI(OpLw, 5'd0, pickReg(), {6'b0, wordIdx, 2'b00});
            endcase
         end
      end else if (kind < 95) begin
         case (sel % 3)
            0: ins = encI(OpSb, 5'd0, pickReg(), {6'b0, wordIdx, lane});
            1: ins = encI(OpSh, 5'd0, pickReg(), {6'b0, wordIdx, lane[1], 1'b0});
            default: ins = encI(OpSw, 5'd0, pickReg(), {6'b0, wordIdx, 2'b00});
         endcase
      end else begin
         // opcodes 0x38..0x3f are not implemented
         ins = {3'b111, rnd[28:0]};
      end
   endtask

   // watchdog
   initial begin
      #(TimeoutNs);
      $display("timeout: stimulus did not complete within %0d ns", TimeoutNs);
      $display("Verification failed");
      $finish;
   end

   initial begin
      wbPort_t     idle;
      word_t       ins;
      logic [31:0] rnd;
      regAddr_t    ra;
      int          assertFails;
      clk        = 1'b0;
      reset      = 1'b0;
      instr      = '0;
      instrValid = 1'b0;
      errorCount = 0;
      checkCount = 0;
      void'($urandom(21));
      aluFuncts  = '{FnAddu, FnSubu, FnAnd, FnOr, FnXor, FnNor,
                     FnSlt, FnSltu, FnSll, FnSrl, FnSra};
      immOps     = '{OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui};
      for (int i = 0; i < 32; i++) begin
         modelRegs[i] = '0;
      end
      for (int i = 0; i < MemWords; i++) begin
         modelMem[i]  = '0;
         byteValid[i] = 4'h0;
      end
      idle = '0;
      // two idle slots cover the pipeline depth
      expQ.push_back(idle);
      expQ.push_back(idle);

      // reset, wb must stay quiet
      for (int i = 0; i < ResetCycles; i++) begin
         @(posedge clk);
         #1;
         if (i == ResetCycles - 1) begin
            reset      = 1'b1;
            instrValid = 1'b0;
         end else begin
            // valid traffic while in reset, all of it has to be dropped
            instr      = $urandom();
            instrValid = 1'b1;
         end
         @(negedge clk);
         compareValue("wb.en", {31'b0, wb.en}, 32'h0);
      end

      // known contents in every register
      for (int r = 1; r < 32; r++) begin
         rnd = $urandom();
         ra  = 5'(r);
         issue(encI(OpLui, 5'd0, ra, rnd[31:16]), 1'b1);
         issue(encI(OpOri, ra, ra, rnd[15:0]), 1'b1);
      end

      for (int n = 0; n < NumRandom; n++) begin
         rnd = $urandom();
         if (rnd[1:0] == 2'b00) begin
            issue($urandom(), 1'b0);
         end
         randomInstr(ins);
         issue(ins, 1'b1);
      end

      // drain the last two slots
      issue('0, 1'b0);
      issue('0, 1'b0);

      assertFails = u_pipeCore.u_pipeCore_chk.failCount;
      $display("checks %0d, errors %0d, assertion failures %0d",
               checkCount, errorCount, assertFails);
      if (errorCount == 0 && assertFails == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: list.f
design/coreTypes.sv
design/aluUnit.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/dataMem.sv
design/resultStage.sv
design/pipeCore.sv
verif/pipeCore_chk.sv
verif/pipeCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
SIMFLAGS  = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = pipeCoreTb
FILELIST  = list.f
OBJDIR    = obj_dir
LOG       = sim.log
PASSMSG   = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
